// ==== hdl/elem_pkg.sv ====
/*
 * element unit package
 * operation and element width encodings, shared data and register types
 */

`default_nettype none

package elem_pkg;

    ////////////////////////////////////////
    // widths

    // one vector element or scalar result
    localparam int unsigned ELEM_W = 32;

    // scalar register number
    localparam int unsigned XREG_ADDR_W = 5;

    ////////////////////////////////////////
    // vector types

    typedef logic [ELEM_W-1:0]      elem_data_t;
    typedef logic [XREG_ADDR_W-1:0] xreg_addr_t;

    ////////////////////////////////////////
    // operation of the current element

    typedef enum logic [3:0] {
        // element 0 to scalar register
        XMV       = 4'd0,
        VID       = 4'd1,
        VIOTA     = 4'd2,
        VFIRST    = 4'd3,
        VCOMPRESS = 4'd4,
        // unmasked reductions
        REDSUM    = 4'd5,
        REDAND    = 4'd6,
        REDOR     = 4'd7,
        REDXOR    = 4'd8,
        REDMINU   = 4'd9,
        REDMIN    = 4'd10,
        REDMAXU   = 4'd11,
        REDMAX    = 4'd12
    } elem_op_t;

    ////////////////////////////////////////
    // effective element width

    typedef enum logic [1:0] {
        EEW_8  = 2'd0,
        EEW_16 = 2'd1,
        EEW_32 = 2'd2
    } elem_eew_t;

endpackage

`default_nettype wire

// ==== hdl/elem_count.sv ====
/*
 * element counters: index, prefix count of set mask bits
 * and the first set mask bit seen in the current operation
 */

`timescale 1ns/1ps
`default_nettype none

module elem_count #(
    parameter int unsigned COUNT_W = 16
) (
    input  wire logic               clk_i,
    input  wire logic               async_rst_ni,
    input  wire logic               accept_i,
    input  wire logic               first_i,
    input  wire logic               en_i,
    input  wire logic               mask_bit_i,
    output logic [COUNT_W-1:0]      index_o,
    output logic [COUNT_W-1:0]      prefix_o,
    output logic                    first_found_o,
    output logic [COUNT_W-1:0]      first_idx_o
);

    logic [COUNT_W-1:0] index_q;
    logic [COUNT_W-1:0] prefix_q;
    logic               found_q;
    logic [COUNT_W-1:0] first_idx_q;

    // state as seen by the current element
    logic               found_prev;
    logic               hit;

    ////////////////////////////////////////
    // current element view

    // a new operation starts from zero
    assign index_o    = first_i ? '0 : index_q;
    assign prefix_o   = first_i ? '0 : prefix_q;
    assign found_prev = first_i ? 1'b0 : found_q;

    // enabled element with its mask bit set
    assign hit = en_i & mask_bit_i;

    assign first_found_o = found_prev | hit;
    assign first_idx_o   = found_prev ? first_idx_q : index_o;

    ////////////////////////////////////////
    // state update on accepted elements

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            index_q     <= '0;
            prefix_q    <= '0;
            found_q     <= 1'b0;
            first_idx_q <= '0;
        end else if (accept_i) begin
            index_q  <= index_o + COUNT_W'(1);
            prefix_q <= prefix_o + COUNT_W'(hit);
            found_q  <= first_found_o;
            // only the first hit of the operation is kept
            if (hit && !found_prev) begin
                first_idx_q <= index_o;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/elem_reduce.sv ====
/*
 * reduction accumulator
 * sum and bitwise reductions on 32 bits, min/max on the low eew bits
 */

`timescale 1ns/1ps
`default_nettype none

module elem_reduce (
    input  wire logic                   clk_i,
    input  wire logic                   async_rst_ni,
    input  wire logic                   accept_i,
    input  wire elem_pkg::elem_op_t     op_i,
    input  wire elem_pkg::elem_eew_t    eew_i,
    input  wire logic                   first_i,
    input  wire logic                   active_i,
    input  wire elem_pkg::elem_data_t   elem_i,
    input  wire elem_pkg::elem_data_t   red_init_i,
    output elem_pkg::elem_data_t        red_o
);

    import elem_pkg::*;

    elem_data_t acc_q;
    elem_data_t start;

    // min/max of a and b over the low eew bits, upper bits taken from b
    function automatic elem_data_t minmax(
        input elem_data_t a,
        input elem_data_t b,
        input elem_eew_t  eew,
        input logic       sgn,
        input logic       pick_max
    );
        logic [32:0] ea;
        logic [32:0] eb;
        elem_data_t  lane;
        logic        take;
        case (eew)
            EEW_8: begin
                lane = 32'h0000_00ff;
                ea   = {{25{sgn & a[7]}}, a[7:0]};
                eb   = {{25{sgn & b[7]}}, b[7:0]};
            end
            EEW_16: begin
                lane = 32'h0000_ffff;
                ea   = {{17{sgn & a[15]}}, a[15:0]};
                eb   = {{17{sgn & b[15]}}, b[15:0]};
            end
            default: begin
                lane = '1;
                ea   = {sgn & a[31], a};
                eb   = {sgn & b[31], b};
            end
        endcase
        // 33-bit extension makes one signed compare serve both kinds
        take = pick_max ? ($signed(ea) > $signed(eb)) : ($signed(ea) < $signed(eb));
        return take ? ((a & lane) | (b & ~lane)) : b;
    endfunction

    ////////////////////////////////////////
    // combine current element

    assign start = first_i ? red_init_i : acc_q;

    always_comb begin
        red_o = start;
        if (active_i) begin
            case (op_i)
                REDSUM:  red_o = start + elem_i;
                REDAND:  red_o = start & elem_i;
                REDOR:   red_o = start | elem_i;
                REDXOR:  red_o = start ^ elem_i;
                REDMINU: red_o = minmax(elem_i, start, eew_i, 1'b0, 1'b0);
                REDMIN:  red_o = minmax(elem_i, start, eew_i, 1'b1, 1'b0);
                REDMAXU: red_o = minmax(elem_i, start, eew_i, 1'b0, 1'b1);
                REDMAX:  red_o = minmax(elem_i, start, eew_i, 1'b1, 1'b1);
                // other operations pass the start value through
                default: red_o = start;
            endcase
        end
    end

    ////////////////////////////////////////
    // accumulator

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            acc_q <= '0;
        end else if (accept_i) begin
            acc_q <= red_o;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/elem_select.sv ====
/*
 * result select
 * per-operation result, write enable, validity and scalar write flag
 */

`timescale 1ns/1ps
`default_nettype none

module elem_select #(
    parameter int unsigned COUNT_W = 16
) (
    input  wire elem_pkg::elem_op_t     op_i,
    input  wire elem_pkg::elem_eew_t    eew_i,
    input  wire logic                   first_i,
    input  wire logic                   last_i,
    input  wire logic                   active_i,
    input  wire logic                   v0_i,
    input  wire logic                   masked_i,
    input  wire elem_pkg::elem_data_t   elem_i,
    input  wire logic                   mask_bit_i,
    input  wire logic [COUNT_W-1:0]     index_i,
    input  wire logic [COUNT_W-1:0]     prefix_i,
    input  wire logic                   first_found_i,
    input  wire logic [COUNT_W-1:0]     first_idx_i,
    input  wire elem_pkg::elem_data_t   red_i,
    output logic                        en_o,
    output elem_pkg::elem_data_t        res_d_o,
    output logic                        res_valid_d_o,
    output logic                        res_we_d_o,
    output logic                        xreg_wr_d_o
);

    import elem_pkg::*;

    elem_data_t index_ext;
    elem_data_t prefix_ext;
    elem_data_t first_ext;
    elem_data_t xmv_ext;

    // element below vl and not masked off by v0
    assign en_o = active_i & (v0_i | ~masked_i);

    // counters widened to element width
    assign index_ext  = elem_data_t'(index_i);
    assign prefix_ext = elem_data_t'(prefix_i);
    // -1 when no set bit has been seen
    assign first_ext  = first_found_i ? elem_data_t'(first_idx_i) : '1;

    always_comb begin
        case (eew_i)
            EEW_8:   xmv_ext = {{24{elem_i[7]}}, elem_i[7:0]};
            EEW_16:  xmv_ext = {{16{elem_i[15]}}, elem_i[15:0]};
            default: xmv_ext = elem_i;
        endcase
    end

    ////////////////////////////////////////
    // result decode

    always_comb begin
        res_d_o       = '0;
        res_valid_d_o = 1'b0;
        res_we_d_o    = 1'b0;
        xreg_wr_d_o   = 1'b0;
        case (op_i)
            XMV: begin
                res_d_o     = xmv_ext;
                xreg_wr_d_o = first_i;
            end
            VFIRST: begin
                res_d_o     = first_ext;
                xreg_wr_d_o = last_i;
            end
            VID: begin
                res_d_o       = index_ext;
                res_valid_d_o = 1'b1;
                res_we_d_o    = en_o;
            end
            VIOTA: begin
                res_d_o       = prefix_ext;
                res_valid_d_o = 1'b1;
                res_we_d_o    = en_o;
            end
            VCOMPRESS: begin
                // only elements with a set mask bit are packed
                res_d_o       = elem_i;
                res_valid_d_o = mask_bit_i & active_i;
                res_we_d_o    = active_i;
            end
            REDSUM, REDAND, REDOR, REDXOR, REDMINU, REDMIN, REDMAXU, REDMAX: begin
                res_d_o       = red_i;
                res_valid_d_o = last_i;
                res_we_d_o    = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/elem_out_stage.sv ====
/*
 * output stage
 * valid/ready result register with scalar write-back outputs
 */

`timescale 1ns/1ps
`default_nettype none

module elem_out_stage (
    input  wire logic                   clk_i,
    input  wire logic                   async_rst_ni,
    input  wire logic                   in_valid_i,
    input  wire logic                   out_ready_i,
    input  wire elem_pkg::elem_data_t   res_d_i,
    input  wire logic                   res_valid_d_i,
    input  wire logic                   res_we_d_i,
    input  wire logic                   xreg_wr_d_i,
    input  wire elem_pkg::xreg_addr_t   rd_i,
    output logic                        in_ready_o,
    output logic                        accept_o,
    output logic                        out_valid_o,
    output elem_pkg::elem_data_t        res_o,
    output logic                        res_valid_o,
    output logic                        res_we_o,
    output logic                        xreg_valid_o,
    output elem_pkg::elem_data_t        xreg_data_o,
    output elem_pkg::xreg_addr_t        xreg_addr_o
);

    import elem_pkg::*;

    logic       valid_q;
    logic       res_valid_q;
    logic       res_we_q;
    logic       xreg_wr_q;
    elem_data_t res_q;
    xreg_addr_t rd_q;

    ////////////////////////////////////////
    // handshake

    // register empty or being drained this cycle
    assign in_ready_o = ~valid_q | out_ready_i;
    assign accept_o   = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q     <= 1'b0;
            res_valid_q <= 1'b0;
            res_we_q    <= 1'b0;
            xreg_wr_q   <= 1'b0;
        end else begin
            if (in_ready_o) begin
                valid_q <= in_valid_i;
            end
            if (accept_o) begin
                res_valid_q <= res_valid_d_i;
                res_we_q    <= res_we_d_i;
                xreg_wr_q   <= xreg_wr_d_i;
            end
        end
    end

    // result payload
    always_ff @(posedge clk_i) begin
        if (accept_o) begin
            res_q <= res_d_i;
            rd_q  <= rd_i;
        end
    end

    ////////////////////////////////////////
    // outputs

    assign out_valid_o  = valid_q;
    assign res_o        = res_q;
    assign res_valid_o  = res_valid_q;
    assign res_we_o     = res_we_q;
    assign xreg_valid_o = valid_q & xreg_wr_q;
    assign xreg_data_o  = res_q;
    assign xreg_addr_o  = rd_q;

endmodule

`default_nettype wire

// ==== hdl/elem_unit.sv ====
/*
 * element-serial vector unit
 * counters, reduction, result select and output register
 */

`timescale 1ns/1ps
`default_nettype none

module elem_unit #(
    parameter int unsigned COUNT_W = 16
) (
    input  wire logic                   clk_i,
    input  wire logic                   async_rst_ni,
    // element input
    input  wire logic                   in_valid_i,
    output logic                        in_ready_o,
    input  wire elem_pkg::elem_op_t     op_i,
    input  wire elem_pkg::elem_eew_t    eew_i,
    input  wire logic                   first_i,
    input  wire logic                   last_i,
    input  wire logic                   active_i,
    input  wire logic                   v0_i,
    input  wire logic                   masked_i,
    input  wire elem_pkg::elem_data_t   elem_i,
    input  wire logic                   mask_bit_i,
    input  wire elem_pkg::elem_data_t   red_init_i,
    input  wire elem_pkg::xreg_addr_t   rd_i,
    // result output
    output logic                        out_valid_o,
    input  wire logic                   out_ready_i,
    output elem_pkg::elem_data_t        res_o,
    output logic                        res_valid_o,
    output logic                        res_we_o,
    output logic                        xreg_valid_o,
    output elem_pkg::elem_data_t        xreg_data_o,
    output elem_pkg::xreg_addr_t        xreg_addr_o
);

    import elem_pkg::*;

    logic               accept;
    logic               en;
    logic [COUNT_W-1:0] index;
    logic [COUNT_W-1:0] prefix;
    logic               first_found;
    logic [COUNT_W-1:0] first_idx;
    elem_data_t         red;
    elem_data_t         res_d;
    logic               res_valid_d;
    logic               res_we_d;
    logic               xreg_wr_d;

    elem_count #(
        .COUNT_W (COUNT_W)
    ) u_count (
        .clk_i         (clk_i),
        .async_rst_ni  (async_rst_ni),
        .accept_i      (accept),
        .first_i       (first_i),
        .en_i          (en),
        .mask_bit_i    (mask_bit_i),
        .index_o       (index),
        .prefix_o      (prefix),
        .first_found_o (first_found),
        .first_idx_o   (first_idx)
    );

    elem_reduce u_reduce (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .accept_i     (accept),
        .op_i         (op_i),
        .eew_i        (eew_i),
        .first_i      (first_i),
        .active_i     (active_i),
        .elem_i       (elem_i),
        .red_init_i   (red_init_i),
        .red_o        (red)
    );

    elem_select #(
        .COUNT_W (COUNT_W)
    ) u_select (
        .op_i          (op_i),
        .eew_i         (eew_i),
        .first_i       (first_i),
        .last_i        (last_i),
        .active_i      (active_i),
        .v0_i          (v0_i),
        .masked_i      (masked_i),
        .elem_i        (elem_i),
        .mask_bit_i    (mask_bit_i),
        .index_i       (index),
        .prefix_i      (prefix),
        .first_found_i (first_found),
        .first_idx_i   (first_idx),
        .red_i         (red),
        .en_o          (en),
        .res_d_o       (res_d),
        .res_valid_d_o (res_valid_d),
        .res_we_d_o    (res_we_d),
        .xreg_wr_d_o   (xreg_wr_d)
    );

    elem_out_stage u_out_stage (
        .clk_i         (clk_i),
        .async_rst_ni  (async_rst_ni),
        .in_valid_i    (in_valid_i),
        .out_ready_i   (out_ready_i),
        .res_d_i       (res_d),
        .res_valid_d_i (res_valid_d),
        .res_we_d_i    (res_we_d),
        .xreg_wr_d_i   (xreg_wr_d),
        .rd_i          (rd_i),
        .in_ready_o    (in_ready_o),
        .accept_o      (accept),
        .out_valid_o   (out_valid_o),
        .res_o         (res_o),
        .res_valid_o   (res_valid_o),
        .res_we_o      (res_we_o),
        .xreg_valid_o  (xreg_valid_o),
        .xreg_data_o   (xreg_data_o),
        .xreg_addr_o   (xreg_addr_o)
    );

endmodule

`default_nettype wire

// ==== tb/elem_unit_sva.sv ====
/*
 * output stage assertions: reset, back-pressure hold and ready rule
 */

`timescale 1ns/1ps
`default_nettype none

module elem_unit_sva (
    input wire logic                 clk_i,
    input wire logic                 async_rst_ni,
    input wire logic                 out_ready_i,
    input wire logic                 in_ready_o,
    input wire logic                 out_valid_o,
    input wire elem_pkg::elem_data_t res_o,
    input wire logic                 res_valid_o,
    input wire logic                 res_we_o,
    input wire logic                 xreg_valid_o,
    input wire elem_pkg::xreg_addr_t xreg_addr_o
);

    // no output item while reset is held
    reset_clear: assert property (@(posedge clk_i) !async_rst_ni |-> !out_valid_o)
        else $error("out_valid_o high during reset");

    // a stalled item holds all of its fields
    stall_hold: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(res_o)
            && $stable(res_valid_o) && $stable(res_we_o)
            && $stable(xreg_valid_o) && $stable(xreg_addr_o)))
        else $error("output changed under back-pressure");

    ready_rule: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        in_ready_o == (!out_valid_o || out_ready_i))
        else $error("in_ready_o does not follow the output register state");

endmodule

bind elem_out_stage elem_unit_sva u_elem_unit_sva (.*);

`default_nettype wire

// ==== tb/elem_unit_tb.sv ====
/*
 * testbench for the element-serial vector unit
 * directed tests checked against a reference model of the result rules
 */

`timescale 1ns/1ps
`default_nettype none

module elem_unit_tb;

    import elem_pkg::*;

    // about six times the roughly 300 cycles that the tests take
    localparam int unsigned MAX_CYCLES = 2000;

    typedef struct packed {
        elem_data_t res;
        logic       res_valid;
        logic       res_we;
        logic       xreg_wr;
        xreg_addr_t rd;
    } expect_t;

    logic       clk_i;
    logic       async_rst_ni;
    logic       in_valid_i;
    logic       in_ready_o;
    elem_op_t   op_i;
    elem_eew_t  eew_i;
    logic       first_i;
    logic       last_i;
    logic       active_i;
    logic       v0_i;
    logic       masked_i;
    elem_data_t elem_i;
    logic       mask_bit_i;
    elem_data_t red_init_i;
    xreg_addr_t rd_i;
    logic       out_valid_o;
    logic       out_ready_i;
    elem_data_t res_o;
    logic       res_valid_o;
    logic       res_we_o;
    logic       xreg_valid_o;
    elem_data_t xreg_data_o;
    xreg_addr_t xreg_addr_o;

    // reference model state
    int unsigned m_idx;
    int unsigned m_pre;
    int unsigned m_first;
    logic        m_found;
    elem_data_t  m_acc;

    expect_t     exp_q[$];
    logic        stall_en;
    int unsigned cycles = 0;

    elem_unit #(
        .COUNT_W (16)
    ) u_elem_unit (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("run timed out after %0d cycles", cycles);
            $display("*** FAILED ***");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////
    // compare tasks

    task automatic check_data(input string name, input elem_data_t got,
                              input elem_data_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_addr(input string name, input xreg_addr_t got,
                              input xreg_addr_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "flag mismatch");
        end
    endtask

    ////////////////////////////////////////
    // reference rules

    function automatic logic rand_bit();
        return 1'($urandom % 2);
    endfunction

    function automatic logic pick_out_ready();
        return stall_en ? rand_bit() : 1'b1;
    endfunction

    function automatic elem_data_t sext_elem(input elem_data_t x, input elem_eew_t eew);
        case (eew)
            EEW_8:   return elem_data_t'(int'($signed(x[7:0])));
            EEW_16:  return elem_data_t'(int'($signed(x[15:0])));
            default: return x;
        endcase
    endfunction

    // value of the low lane as a plain number
    function automatic longint lane_val(input elem_data_t x, input elem_data_t lane,
                                        input logic sgn);
        longint v;
        v = longint'(x & lane);
        if (sgn && ((x & ((lane >> 1) + 1)) != 0)) begin
            v = v - (longint'(lane) + 1);
        end
        return v;
    endfunction

    function automatic elem_data_t red_ref(input elem_op_t op, input elem_eew_t eew,
                                           input elem_data_t acc, input elem_data_t e);
        elem_data_t lane;
        logic       sgn;
        logic       pick;
        longint     a;
        longint     b;
        lane = (eew == EEW_8) ? 32'hff : (eew == EEW_16) ? 32'hffff : 32'hffff_ffff;
        sgn  = (op == REDMIN) || (op == REDMAX);
        a    = lane_val(e, lane, sgn);
        b    = lane_val(acc, lane, sgn);
        case (op)
            REDSUM:           return acc + e;
            REDAND:           return acc & e;
            REDOR:            return acc | e;
            REDXOR:           return acc ^ e;
            REDMINU, REDMIN:  pick = a < b;
            REDMAXU, REDMAX:  pick = a > b;
            default:          return acc;
        endcase
        return pick ? ((e & lane) | (acc & ~lane)) : acc;
    endfunction

    ////////////////////////////////////////
    // driving and output checks

    task automatic check_out();
        expect_t e;
        if (exp_q.size() == 0) begin
            $display("output item at %0t with no element pending", $time);
            $display("*** FAILED ***");
            $fatal(1, "unexpected output");
        end else begin
            e = exp_q.pop_front();
            check_data("res_o", res_o, e.res);
            check_flag("res_valid_o", res_valid_o, e.res_valid);
            check_flag("res_we_o", res_we_o, e.res_we);
            check_flag("xreg_valid_o", xreg_valid_o, e.xreg_wr);
            check_data("xreg_data_o", xreg_data_o, e.res);
            check_addr("xreg_addr_o", xreg_addr_o, e.rd);
        end
    endtask

    // output side as seen at one clock edge
    task automatic sample_out();
        if (out_valid_o && out_ready_i) begin
            check_out();
        end else if (!out_valid_o) begin
            // no scalar write without an output item
            check_flag("xreg_valid_o", xreg_valid_o, 1'b0);
        end
    endtask

    task automatic send_elem(
        input elem_op_t   op,
        input elem_eew_t  eew,
        input logic       first,
        input logic       last,
        input logic       active,
        input logic       masked,
        input logic       v0,
        input logic       mask_bit,
        input elem_data_t data,
        input elem_data_t init,
        input xreg_addr_t rd
    );
        expect_t    e;
        elem_data_t start;
        logic       en;
        logic       hit;
        logic       taken;
        if (first) begin
            m_idx   = 0;
            m_pre   = 0;
            m_found = 1'b0;
        end
        en  = active && (v0 || !masked);
        hit = en && mask_bit;
        if (hit && !m_found) begin
            m_found = 1'b1;
            m_first = m_idx;
        end
        start       = first ? init : m_acc;
        m_acc       = active ? red_ref(op, eew, start, data) : start;
        e.rd        = rd;
        e.res       = '0;
        e.res_valid = 1'b0;
        e.res_we    = 1'b0;
        e.xreg_wr   = 1'b0;
        case (op)
            XMV: begin
                e.res     = sext_elem(data, eew);
                e.xreg_wr = first;
            end
            VID, VIOTA: begin
                e.res       = (op == VID) ? m_idx : m_pre;
                e.res_valid = 1'b1;
                e.res_we    = en;
            end
            VFIRST: begin
                e.res     = m_found ? elem_data_t'(m_first) : '1;
                e.xreg_wr = last;
            end
            VCOMPRESS: begin
                e.res       = data;
                e.res_valid = mask_bit && active;
                e.res_we    = active;
            end
            default: begin
                e.res       = m_acc;
                e.res_valid = last;
                e.res_we    = 1'b1;
            end
        endcase
        m_idx = m_idx + 1;
        m_pre = m_pre + (hit ? 1 : 0);
        exp_q.push_back(e);
        op_i       = op;
        eew_i      = eew;
        first_i    = first;
        last_i     = last;
        active_i   = active;
        masked_i   = masked;
        v0_i       = v0;
        mask_bit_i = mask_bit;
        elem_i     = data;
        red_init_i = init;
        rd_i       = rd;
        in_valid_i = 1'b1;
        // hold the element until the handshake completes
        do begin
            @(posedge clk_i);
            sample_out();
            taken = in_ready_o;
            @(negedge clk_i);
            out_ready_i = pick_out_ready();
        end while (!taken);
        in_valid_i = 1'b0;
    endtask

    task automatic drain();
        in_valid_i = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
            sample_out();
            @(negedge clk_i);
            out_ready_i = pick_out_ready();
        end
    endtask

    ////////////////////////////////////////
    // directed tests

    task automatic test_reset_latency();
        check_flag("out_valid_o", out_valid_o, 1'b0);
        check_flag("xreg_valid_o", xreg_valid_o, 1'b0);
        send_elem(XMV, EEW_32, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 32'h1234_5678, '0, 5'd3);
        // item is visible one cycle after acceptance
        check_flag("out_valid_o", out_valid_o, 1'b1);
        drain();
    endtask

    task automatic test_xmv_vfirst();
        elem_eew_t  eews[3];
        logic       masked;
        logic       mb;
        xreg_addr_t rd;
        eews = '{EEW_8, EEW_16, EEW_32};
        foreach (eews[k]) begin
            rd = xreg_addr_t'($urandom);
            for (int i = 0; i < 3; i++) begin
                send_elem(XMV, eews[k], i == 0, i == 2, 1'b1, 1'b0, 1'b0, 1'b0,
                          $urandom, '0, rd);
            end
        end
        // last pass has no set mask bit at all
        for (int r = 0; r < 3; r++) begin
            masked = rand_bit();
            rd     = xreg_addr_t'($urandom);
            for (int i = 0; i < 8; i++) begin
                mb = (r == 2) ? 1'b0 : ($urandom % 4 == 0);
                send_elem(VFIRST, EEW_32, i == 0, i == 7, i < 6, masked, rand_bit(), mb,
                          $urandom, '0, rd);
            end
        end
        drain();
    endtask

    task automatic test_vid_viota();
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < 16; i++) begin
                send_elem((p == 0) ? VID : VIOTA, EEW_32, i == 0, i == 15, i < 12, 1'b1,
                          rand_bit(), rand_bit(), $urandom, '0, 5'd0);
            end
        end
        drain();
    endtask

    task automatic test_vcompress();
        for (int i = 0; i < 10; i++) begin
            send_elem(VCOMPRESS, EEW_32, i == 0, i == 9, i < 8, 1'b0, 1'b0, rand_bit(),
                      $urandom, '0, 5'd0);
        end
        drain();
    endtask

    task automatic test_reductions();
        elem_op_t    ops[8];
        elem_eew_t   eews[3];
        elem_data_t  init;
        int unsigned n_act;
        ops  = '{REDSUM, REDAND, REDOR, REDXOR, REDMINU, REDMIN, REDMAXU, REDMAX};
        eews = '{EEW_8, EEW_16, EEW_32};
        foreach (ops[o]) begin
            foreach (eews[k]) begin
                init  = $urandom;
                n_act = 3 + $urandom % 4;
                for (int i = 0; i < 6; i++) begin
                    send_elem(ops[o], eews[k], i == 0, i == 5, i < n_act, 1'b0, 1'b0, 1'b0,
                              $urandom, init, 5'd0);
                end
            end
        end
        drain();
    endtask

    task automatic test_stalls();
        stall_en = 1'b1;
        for (int i = 0; i < 16; i++) begin
            send_elem(VID, EEW_32, i == 0, i == 15, 1'b1, 1'b0, 1'b0, 1'b0,
                      $urandom, '0, 5'd0);
        end
        drain();
        stall_en    = 1'b0;
        out_ready_i = 1'b1;
    endtask

    initial begin
        void'($urandom(55741));
        async_rst_ni = 1'b0;
        in_valid_i   = 1'b0;
        op_i         = XMV;
        eew_i        = EEW_32;
        first_i      = 1'b0;
        last_i       = 1'b0;
        active_i     = 1'b0;
        v0_i         = 1'b0;
        masked_i     = 1'b0;
        elem_i       = '0;
        mask_bit_i   = 1'b0;
        red_init_i   = '0;
        rd_i         = '0;
        out_ready_i  = 1'b1;
        stall_en     = 1'b0;
        m_idx        = 0;
        m_pre        = 0;
        m_first      = 0;
        m_found      = 1'b0;
        m_acc        = '0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        async_rst_ni = 1'b1;
        test_reset_latency();
        test_xmv_vfirst();
        test_vid_viota();
        test_vcompress();
        test_reductions();
        test_stalls();
        if (exp_q.size() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("%0d expected items never left the DUT", exp_q.size());
            $display("*** FAILED ***");
            $fatal(1, "items lost");
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/elem_pkg.sv
hdl/elem_count.sv
hdl/elem_reduce.sv
hdl/elem_select.sv
hdl/elem_out_stage.sv
hdl/elem_unit.sv
tb/elem_unit_sva.sv
tb/elem_unit_tb.sv
